// ==== logic/rooth_pkg.sv ====
package rooth_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int CPU_WIDTH    = 32;   // data and address
    localparam int FLOW_WIDTH   = 2;
    localparam int WIDTH_BRANCH = 3;
    localparam int WIDTH_JUMP   = 2;

    // flow commands for pc and stage registers
    localparam logic [FLOW_WIDTH-1:0] FLOW_WORK    = 2'd0;  // advance
    localparam logic [FLOW_WIDTH-1:0] FLOW_STOP    = 2'd1;  // hold
    localparam logic [FLOW_WIDTH-1:0] FLOW_REFRESH = 2'd2;  // bubble

    // branch types, none must stay zero
    localparam logic [WIDTH_BRANCH-1:0] BRANCH_NONE = 3'd0;
    localparam logic [WIDTH_BRANCH-1:0] BRANCH_BEQ  = 3'd1;
    localparam logic [WIDTH_BRANCH-1:0] BRANCH_BNE  = 3'd2;
    localparam logic [WIDTH_BRANCH-1:0] BRANCH_BLT  = 3'd3;
    localparam logic [WIDTH_BRANCH-1:0] BRANCH_BGE  = 3'd4;
    localparam logic [WIDTH_BRANCH-1:0] BRANCH_BLTU = 3'd5;
    localparam logic [WIDTH_BRANCH-1:0] BRANCH_BGEU = 3'd6;

    // jump types
    localparam logic [WIDTH_JUMP-1:0] JUMP_NONE  = 2'd0;
    localparam logic [WIDTH_JUMP-1:0] JUMP_JAL   = 2'd1;
    localparam logic [WIDTH_JUMP-1:0] JUMP_JALR  = 2'd2;
    localparam logic [WIDTH_JUMP-1:0] JUMP_FENCE = 2'd3;

    localparam logic [CPU_WIDTH-1:0] RESET_PC = 32'h0000_0000;

    // what the execute stage register carries
    typedef struct packed {
        logic [CPU_WIDTH-1:0]    pc;
        logic [WIDTH_BRANCH-1:0] branch;
        logic [WIDTH_JUMP-1:0]   jump;
        logic [CPU_WIDTH-1:0]    imm;
        logic [CPU_WIDTH-1:0]    rs1;
        logic [CPU_WIDTH-1:0]    rs2;
    } ex_entry_t;

endpackage

// ==== logic/branch_compare.sv ====
`timescale 1ns/1ps

module branch_compare (
    input  logic [rooth_pkg::CPU_WIDTH-1:0]    rs1_i,
    input  logic [rooth_pkg::CPU_WIDTH-1:0]    rs2_i,
    input  logic [rooth_pkg::WIDTH_BRANCH-1:0] branch_i,
    output logic                               zero_o,      // rs1 == rs2
    output logic                               less_o,
    output logic                               more_zero_o  // rs1 >= rs2
);

    logic less_signed;
    logic less_unsigned;

    assign less_signed   = $signed(rs1_i) < $signed(rs2_i);
    assign less_unsigned = rs1_i < rs2_i;

    assign zero_o = (rs1_i == rs2_i);

    // unsigned only for the u variants
    always_comb begin
        case (branch_i)
            rooth_pkg::BRANCH_BLTU,
            rooth_pkg::BRANCH_BGEU: less_o = less_unsigned;
            default:                less_o = less_signed;
        endcase
    end

    assign more_zero_o = ~less_o;

endmodule

// ==== logic/pipeline_ctrl.sv ====
`timescale 1ns/1ps

module pipeline_ctrl (
    input  logic                               jtag_halt_flag_i,
    input  logic [rooth_pkg::WIDTH_BRANCH-1:0] branch_i,        // from ex stage
    input  logic [rooth_pkg::CPU_WIDTH-1:0]    pc_adder_i,      // pc of ex stage
    input  logic                               zero_i,
    input  logic                               more_zero_i,
    input  logic                               less_i,
    input  logic [rooth_pkg::WIDTH_JUMP-1:0]   jump_i,
    input  logic [rooth_pkg::CPU_WIDTH-1:0]    imm_i,
    input  logic [rooth_pkg::CPU_WIDTH-1:0]    reg1_rd_data_i,  // jalr base
    input  logic                               fetch_pc_hold_i,
    input  logic                               alu_busy_i,      // divider busy
    input  logic                               access_mem_hold_i,
    input  logic [1:0]                         pr_access_instmem_i,
    input  logic                               clint_hold_flag_i,
    input  logic [rooth_pkg::CPU_WIDTH-1:0]    clint_int_addr_i,
    input  logic                               clint_int_assert_i,
    input  logic                               flow_wait_fc_i,  // fence wait
    output logic [rooth_pkg::CPU_WIDTH-1:0]    next_pc_o,
    output logic                               next_pc_four_o,
    output logic [rooth_pkg::FLOW_WIDTH-1:0]   flow_pc_o,
    output logic [rooth_pkg::FLOW_WIDTH-1:0]   flow_de_o,
    output logic [rooth_pkg::FLOW_WIDTH-1:0]   flow_ex_o,
    output logic [rooth_pkg::FLOW_WIDTH-1:0]   flow_as_o,
    output logic [rooth_pkg::FLOW_WIDTH-1:0]   flow_wb_o
);

    logic branch_taken;

    // ----------------------------------------
    // branch condition
    // ----------------------------------------
    always_comb begin
        case (branch_i)
            rooth_pkg::BRANCH_BEQ:  branch_taken = zero_i;
            rooth_pkg::BRANCH_BNE:  branch_taken = !zero_i;
            rooth_pkg::BRANCH_BLT,
            rooth_pkg::BRANCH_BLTU: branch_taken = less_i;
            rooth_pkg::BRANCH_BGE,
            rooth_pkg::BRANCH_BGEU: branch_taken = more_zero_i;
            default:                branch_taken = 1'b0;
        endcase
    end

    // ----------------------------------------
    // priority chain, interrupt first
    // ----------------------------------------
    always_comb begin
        next_pc_o      = '0;
        next_pc_four_o = 1'b0;
        flow_pc_o      = rooth_pkg::FLOW_WORK;
        flow_de_o      = rooth_pkg::FLOW_WORK;
        flow_ex_o      = rooth_pkg::FLOW_WORK;
        flow_as_o      = rooth_pkg::FLOW_WORK;
        flow_wb_o      = rooth_pkg::FLOW_WORK;

        if (clint_int_assert_i) begin
            // flush everything behind fetch
            next_pc_o = clint_int_addr_i;
            flow_de_o = rooth_pkg::FLOW_REFRESH;
            flow_ex_o = rooth_pkg::FLOW_REFRESH;
            flow_as_o = rooth_pkg::FLOW_REFRESH;
            flow_wb_o = rooth_pkg::FLOW_REFRESH;
        end else if (clint_hold_flag_i || jtag_halt_flag_i) begin
            flow_pc_o = rooth_pkg::FLOW_STOP;   // whole pipe frozen
            flow_de_o = rooth_pkg::FLOW_STOP;
            flow_ex_o = rooth_pkg::FLOW_STOP;
            flow_as_o = rooth_pkg::FLOW_STOP;
            flow_wb_o = rooth_pkg::FLOW_STOP;
        end else if (access_mem_hold_i) begin
            flow_pc_o = rooth_pkg::FLOW_STOP;
            flow_de_o = rooth_pkg::FLOW_STOP;
            flow_ex_o = rooth_pkg::FLOW_STOP;
            flow_as_o = rooth_pkg::FLOW_STOP;
            flow_wb_o = rooth_pkg::FLOW_REFRESH;
        end else if (flow_wait_fc_i || pr_access_instmem_i[1] || alu_busy_i) begin
            // ex waits, wb drains
            flow_pc_o = rooth_pkg::FLOW_STOP;
            flow_de_o = rooth_pkg::FLOW_STOP;
            flow_ex_o = rooth_pkg::FLOW_STOP;
            flow_as_o = rooth_pkg::FLOW_REFRESH;
        end else if (pr_access_instmem_i[0]) begin
            flow_pc_o = rooth_pkg::FLOW_STOP;
            flow_de_o = rooth_pkg::FLOW_STOP;
            flow_ex_o = rooth_pkg::FLOW_REFRESH;
        end else if (fetch_pc_hold_i) begin
            flow_pc_o = rooth_pkg::FLOW_STOP;
            flow_de_o = rooth_pkg::FLOW_REFRESH; // fetch gives nothing
        end else if (branch_i != rooth_pkg::BRANCH_NONE) begin
            if (branch_taken) begin
                next_pc_o = pc_adder_i + imm_i;
                flow_de_o = rooth_pkg::FLOW_REFRESH;
                flow_ex_o = rooth_pkg::FLOW_REFRESH;
            end else begin
                next_pc_four_o = 1'b1;
            end
        end else if (jump_i != rooth_pkg::JUMP_NONE) begin
            flow_de_o = rooth_pkg::FLOW_REFRESH;
            flow_ex_o = rooth_pkg::FLOW_REFRESH;
            case (jump_i)
                rooth_pkg::JUMP_JAL:  next_pc_o = pc_adder_i + imm_i;
                rooth_pkg::JUMP_JALR: next_pc_o = reg1_rd_data_i + imm_i;
                default: begin
                    // fence refetches the next instruction
                    next_pc_o = pc_adder_i + (rooth_pkg::CPU_WIDTH)'(4);
                end
            endcase
        end else begin
            next_pc_four_o = 1'b1;
        end
    end

endmodule

// ==== logic/pc_reg.sv ====
`timescale 1ns/1ps

module pc_reg (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [rooth_pkg::FLOW_WIDTH-1:0] flow_i,
    input  logic [rooth_pkg::CPU_WIDTH-1:0]  next_pc_i,      // redirect target
    input  logic                             next_pc_four_i, // sequential step
    output logic [rooth_pkg::CPU_WIDTH-1:0]  pc_o
);

    logic [rooth_pkg::CPU_WIDTH-1:0] pc_next;

    always_comb begin
        if (next_pc_four_i) begin
            pc_next = pc_o + (rooth_pkg::CPU_WIDTH)'(4);
        end else begin
            pc_next = next_pc_i;
        end
    end

    // stop and refresh both keep the fetch address
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_o <= rooth_pkg::RESET_PC;
        end else if (flow_i == rooth_pkg::FLOW_WORK) begin
            pc_o <= pc_next;
        end
    end

    // targets from the controller and the interrupt entry must be aligned
    a_pc_aligned : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pc_o[1:0] == 2'b00
    ) else $error("pc_reg: fetch address %h not word aligned", pc_o);

endmodule

// ==== logic/flow_stage_reg.sv ====
`timescale 1ns/1ps

module flow_stage_reg #(
    parameter type payload_t = logic [rooth_pkg::CPU_WIDTH-1:0]
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [rooth_pkg::FLOW_WIDTH-1:0] flow_i,
    input  payload_t                         data_i,
    input  logic                             valid_i,
    output payload_t                         data_o,
    output logic                             valid_o
);

    // ----------------------------------------
    // load, hold or bubble
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_o  <= '0;
            valid_o <= 1'b0;
        end else begin
            case (flow_i)
                rooth_pkg::FLOW_WORK: begin
                    if (valid_i) begin
                        data_o <= data_i;
                    end else begin
                        data_o <= '0;   // empty slot moves on as a bubble
                    end
                    valid_o <= valid_i;
                end
                rooth_pkg::FLOW_REFRESH: begin
                    // zero payload means no branch and no jump
                    data_o  <= '0;
                    valid_o <= 1'b0;
                end
                default: begin
                    data_o  <= data_o;   // stop
                    valid_o <= valid_o;
                end
            endcase
        end
    end

endmodule

// ==== logic/rooth_flow_core.sv ====
`timescale 1ns/1ps

module rooth_flow_core (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               jtag_halt_i,
    input  logic                               clint_hold_i,
    input  logic                               clint_int_assert_i,
    input  logic [rooth_pkg::CPU_WIDTH-1:0]    clint_int_addr_i,
    input  logic                               access_mem_hold_i,
    input  logic                               alu_busy_i,
    input  logic                               fetch_pc_hold_i,
    input  logic                               flow_wait_fc_i,
    input  logic [1:0]                         pr_access_instmem_i,
    input  logic [rooth_pkg::WIDTH_BRANCH-1:0] dec_branch_i,   // decode fields
    input  logic [rooth_pkg::WIDTH_JUMP-1:0]   dec_jump_i,
    input  logic [rooth_pkg::CPU_WIDTH-1:0]    dec_imm_i,
    input  logic [rooth_pkg::CPU_WIDTH-1:0]    dec_rs1_i,
    input  logic [rooth_pkg::CPU_WIDTH-1:0]    dec_rs2_i,
    output logic [rooth_pkg::CPU_WIDTH-1:0]    fetch_pc_o,
    output logic                               de_valid_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]    de_pc_o,
    output logic                               ex_valid_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]    ex_pc_o,
    output logic                               as_valid_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]    as_pc_o,
    output logic                               wb_valid_o,
    output logic [rooth_pkg::CPU_WIDTH-1:0]    wb_pc_o
);

    logic [rooth_pkg::FLOW_WIDTH-1:0] flow_pc;
    logic [rooth_pkg::FLOW_WIDTH-1:0] flow_de;
    logic [rooth_pkg::FLOW_WIDTH-1:0] flow_ex;
    logic [rooth_pkg::FLOW_WIDTH-1:0] flow_as;
    logic [rooth_pkg::FLOW_WIDTH-1:0] flow_wb;
    logic [rooth_pkg::CPU_WIDTH-1:0]  next_pc;
    logic                             next_pc_four;
    logic                             zero;
    logic                             less;
    logic                             more_zero;
    rooth_pkg::ex_entry_t             ex_in;
    rooth_pkg::ex_entry_t             ex_q;

    // decode fields joined with the de pc
    assign ex_in.pc     = de_pc_o;
    assign ex_in.branch = dec_branch_i;
    assign ex_in.jump   = dec_jump_i;
    assign ex_in.imm    = dec_imm_i;
    assign ex_in.rs1    = dec_rs1_i;
    assign ex_in.rs2    = dec_rs2_i;

    assign ex_pc_o = ex_q.pc;

    // ----------------------------------------
    // fetch and stage registers
    // ----------------------------------------
    pc_reg i_pc_reg (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flow_i         (flow_pc),
        .next_pc_i      (next_pc),
        .next_pc_four_i (next_pc_four),
        .pc_o           (fetch_pc_o)
    );

    flow_stage_reg #(
        .payload_t (logic [rooth_pkg::CPU_WIDTH-1:0])
    ) i_de_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flow_i  (flow_de),
        .data_i  (fetch_pc_o),
        .valid_i (1'b1),            // fetch always offers a word
        .data_o  (de_pc_o),
        .valid_o (de_valid_o)
    );

    flow_stage_reg #(
        .payload_t (rooth_pkg::ex_entry_t)
    ) i_ex_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flow_i  (flow_ex),
        .data_i  (ex_in),
        .valid_i (de_valid_o),
        .data_o  (ex_q),
        .valid_o (ex_valid_o)
    );

    flow_stage_reg #(
        .payload_t (logic [rooth_pkg::CPU_WIDTH-1:0])
    ) i_as_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flow_i  (flow_as),
        .data_i  (ex_q.pc),
        .valid_i (ex_valid_o),
        .data_o  (as_pc_o),
        .valid_o (as_valid_o)
    );

    flow_stage_reg #(
        .payload_t (logic [rooth_pkg::CPU_WIDTH-1:0])
    ) i_wb_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flow_i  (flow_wb),
        .data_i  (as_pc_o),
        .valid_i (as_valid_o),
        .data_o  (wb_pc_o),
        .valid_o (wb_valid_o)
    );

    // ----------------------------------------
    // ex stage decision
    // ----------------------------------------
    branch_compare i_branch_compare (
        .rs1_i       (ex_q.rs1),
        .rs2_i       (ex_q.rs2),
        .branch_i    (ex_q.branch),
        .zero_o      (zero),
        .less_o      (less),
        .more_zero_o (more_zero)
    );

    pipeline_ctrl i_pipeline_ctrl (
        .jtag_halt_flag_i    (jtag_halt_i),
        .branch_i            (ex_q.branch),
        .pc_adder_i          (ex_q.pc),
        .zero_i              (zero),
        .more_zero_i         (more_zero),
        .less_i              (less),
        .jump_i              (ex_q.jump),
        .imm_i               (ex_q.imm),
        .reg1_rd_data_i      (ex_q.rs1),
        .fetch_pc_hold_i     (fetch_pc_hold_i),
        .alu_busy_i          (alu_busy_i),
        .access_mem_hold_i   (access_mem_hold_i),
        .pr_access_instmem_i (pr_access_instmem_i),
        .clint_hold_flag_i   (clint_hold_i),
        .clint_int_addr_i    (clint_int_addr_i),
        .clint_int_assert_i  (clint_int_assert_i),
        .flow_wait_fc_i      (flow_wait_fc_i),
        .next_pc_o           (next_pc),
        .next_pc_four_o      (next_pc_four),
        .flow_pc_o           (flow_pc),
        .flow_de_o           (flow_de),
        .flow_ex_o           (flow_ex),
        .flow_as_o           (flow_as),
        .flow_wb_o           (flow_wb)
    );

endmodule

// ==== verification/rooth_flow_core_tb.sv ====
`timescale 1ns/1ps

module rooth_flow_core_tb;

    logic                               clk;
    logic                               rst_n;
    logic                               jtag_halt;
    logic                               clint_hold;
    logic                               clint_int_assert;
    logic [rooth_pkg::CPU_WIDTH-1:0]    clint_int_addr;
    logic                               access_mem_hold;
    logic                               alu_busy;
    logic                               fetch_pc_hold;
    logic                               flow_wait_fc;
    logic [1:0]                         pr_access_instmem;
    logic [rooth_pkg::WIDTH_BRANCH-1:0] dec_branch;
    logic [rooth_pkg::WIDTH_JUMP-1:0]   dec_jump;
    logic [rooth_pkg::CPU_WIDTH-1:0]    dec_imm;
    logic [rooth_pkg::CPU_WIDTH-1:0]    dec_rs1;
    logic [rooth_pkg::CPU_WIDTH-1:0]    dec_rs2;
    logic [rooth_pkg::CPU_WIDTH-1:0]    fetch_pc;
    logic                               de_valid;
    logic [rooth_pkg::CPU_WIDTH-1:0]    de_pc;
    logic                               ex_valid;
    logic [rooth_pkg::CPU_WIDTH-1:0]    ex_pc;
    logic                               as_valid;
    logic [rooth_pkg::CPU_WIDTH-1:0]    as_pc;
    logic                               wb_valid;
    logic [rooth_pkg::CPU_WIDTH-1:0]    wb_pc;

    logic                               seq_on;     // phase flags for the checks
    logic                               branch_on;
    logic                               jalr_on;
    logic                               any_hold;
    int unsigned                        cycle_count = 0;

    // one cycle of history
    logic [rooth_pkg::CPU_WIDTH-1:0]    fetch_pc_q;
    logic [rooth_pkg::CPU_WIDTH-1:0]    de_pc_q;
    logic [rooth_pkg::CPU_WIDTH-1:0]    ex_pc_q;
    logic [rooth_pkg::CPU_WIDTH-1:0]    as_pc_q;
    logic                               ex_valid_q;
    logic                               hold_q;
    logic                               irq_q;
    logic [rooth_pkg::CPU_WIDTH-1:0]    irq_addr_q;

    rooth_flow_core i_rooth_flow_core (
        .clk_i               (clk),
        .rst_n_i             (rst_n),
        .jtag_halt_i         (jtag_halt),
        .clint_hold_i        (clint_hold),
        .clint_int_assert_i  (clint_int_assert),
        .clint_int_addr_i    (clint_int_addr),
        .access_mem_hold_i   (access_mem_hold),
        .alu_busy_i          (alu_busy),
        .fetch_pc_hold_i     (fetch_pc_hold),
        .flow_wait_fc_i      (flow_wait_fc),
        .pr_access_instmem_i (pr_access_instmem),
        .dec_branch_i        (dec_branch),
        .dec_jump_i          (dec_jump),
        .dec_imm_i           (dec_imm),
        .dec_rs1_i           (dec_rs1),
        .dec_rs2_i           (dec_rs2),
        .fetch_pc_o          (fetch_pc),
        .de_valid_o          (de_valid),
        .de_pc_o             (de_pc),
        .ex_valid_o          (ex_valid),
        .ex_pc_o             (ex_pc),
        .as_valid_o          (as_valid),
        .as_pc_o             (as_pc),
        .wb_valid_o          (wb_valid),
        .wb_pc_o             (wb_pc)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    assign any_hold = jtag_halt | clint_hold | access_mem_hold | alu_busy
                    | fetch_pc_hold | flow_wait_fc | (|pr_access_instmem);

    always @(posedge clk) begin
        fetch_pc_q <= fetch_pc;
        de_pc_q    <= de_pc;
        ex_pc_q    <= ex_pc;
        as_pc_q    <= as_pc;
        ex_valid_q <= ex_valid;
        hold_q     <= any_hold;
        irq_q      <= clint_int_assert;
        irq_addr_q <= clint_int_addr;
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH %s expected %h actual %h", test, expected, actual);
        abort_run();
    endtask

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_reset_pc : assert property (@(posedge clk) $rose(rst_n) |-> fetch_pc == rooth_pkg::RESET_PC)
        else report_mismatch("reset", rooth_pkg::RESET_PC, fetch_pc);
    a_reset_valid : assert property (@(posedge clk)
        $rose(rst_n) |-> {de_valid, ex_valid, as_valid, wb_valid} == 4'b0000)
        else report_mismatch("reset", 32'h0, {28'h0, de_valid, ex_valid, as_valid, wb_valid});

    a_seq_fetch : assert property (@(posedge clk) disable iff (!rst_n)
        seq_on |-> fetch_pc == fetch_pc_q + 32'd4)
        else report_mismatch("sequential", fetch_pc_q + 32'd4, fetch_pc);
    a_seq_de : assert property (@(posedge clk) disable iff (!rst_n) seq_on |-> de_pc == fetch_pc_q)
        else report_mismatch("sequential", fetch_pc_q, de_pc);
    a_seq_ex : assert property (@(posedge clk) disable iff (!rst_n) seq_on |-> ex_pc == de_pc_q)
        else report_mismatch("sequential", de_pc_q, ex_pc);
    a_seq_as : assert property (@(posedge clk) disable iff (!rst_n) seq_on |-> as_pc == ex_pc_q)
        else report_mismatch("sequential", ex_pc_q, as_pc);
    a_seq_wb : assert property (@(posedge clk) disable iff (!rst_n) seq_on |-> wb_pc == as_pc_q)
        else report_mismatch("sequential", as_pc_q, wb_pc);

    a_stall : assert property (@(posedge clk) disable iff (!rst_n)
        hold_q && !irq_q |-> fetch_pc == fetch_pc_q)
        else report_mismatch("stall", fetch_pc_q, fetch_pc);

    // imm stays constant while branch_on is set
    a_branch_target : assert property (@(posedge clk) disable iff (!rst_n)
        branch_on && ex_valid_q |-> fetch_pc == ex_pc_q + dec_imm)
        else report_mismatch("taken branch", ex_pc_q + dec_imm, fetch_pc);
    a_branch_bubble : assert property (@(posedge clk) disable iff (!rst_n)
        branch_on && ex_valid_q |-> !de_valid && !ex_valid)
        else report_mismatch("taken branch", 32'h0, {30'h0, de_valid, ex_valid});

    a_jalr : assert property (@(posedge clk) disable iff (!rst_n)
        jalr_on && ex_valid_q |-> fetch_pc == dec_rs1 + dec_imm)
        else report_mismatch("jalr", dec_rs1 + dec_imm, fetch_pc);

    a_irq_pc : assert property (@(posedge clk) disable iff (!rst_n) irq_q |-> fetch_pc == irq_addr_q)
        else report_mismatch("interrupt", irq_addr_q, fetch_pc);
    a_irq_flush : assert property (@(posedge clk) disable iff (!rst_n)
        irq_q |-> {de_valid, ex_valid, as_valid, wb_valid} == 4'b0000)
        else report_mismatch("interrupt", 32'h0, {28'h0, de_valid, ex_valid, as_valid, wb_valid});

    // reset plus six phases of 66 cycles is about 400
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == 1000) begin
            $display("timeout: run did not finish within 1000 cycles");
            abort_run();
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic clear_inputs();
        jtag_halt         <= 1'b0;
        clint_hold        <= 1'b0;
        clint_int_assert  <= 1'b0;
        clint_int_addr    <= '0;
        access_mem_hold   <= 1'b0;
        alu_busy          <= 1'b0;
        fetch_pc_hold     <= 1'b0;
        flow_wait_fc      <= 1'b0;
        pr_access_instmem <= 2'b00;
        dec_branch        <= rooth_pkg::BRANCH_NONE;
        dec_jump          <= rooth_pkg::JUMP_NONE;
    endtask

    task automatic pulse_random_holds();
        int pick;
        pick = $urandom % 12;   // a hold on two cycles in three
        jtag_halt         <= (pick == 0);
        clint_hold        <= (pick == 1);
        access_mem_hold   <= (pick == 2);
        alu_busy          <= (pick == 3);
        fetch_pc_hold     <= (pick == 4);
        flow_wait_fc      <= (pick == 5);
        pr_access_instmem <= (pick == 6) ? 2'b01 : ((pick == 7) ? 2'b10 : 2'b00);
        clint_int_assert  <= ($urandom % 10 == 0);
        clint_int_addr    <= $urandom & 32'hffff_fffc;  // word aligned entry
    endtask

    task automatic run_phase(
        input logic [rooth_pkg::WIDTH_BRANCH-1:0] branch,
        input logic [rooth_pkg::WIDTH_JUMP-1:0]   jump,
        input logic [rooth_pkg::CPU_WIDTH-1:0]    imm,
        input logic [rooth_pkg::CPU_WIDTH-1:0]    rs1,
        input logic [rooth_pkg::CPU_WIDTH-1:0]    rs2,
        input logic                               noisy,
        input logic [2:0]                         arm
    );
        {seq_on, branch_on, jalr_on} <= 3'b000;
        clear_inputs();
        repeat (4) @(posedge clk);  // plain instructions refill de and ex
        dec_branch <= branch;
        dec_jump   <= jump;
        dec_imm    <= imm;
        dec_rs1    <= rs1;
        dec_rs2    <= rs2;
        repeat (2) @(posedge clk);  // first new entry reaches ex
        {seq_on, branch_on, jalr_on} <= arm;
        repeat (60) begin
            @(posedge clk);
            if (noisy) begin
                pulse_random_holds();
            end
        end
    endtask

    initial begin
        void'($urandom(32'h5325abec));
        rst_n <= 1'b0;
        {seq_on, branch_on, jalr_on} <= 3'b000;
        dec_imm <= '0;
        dec_rs1 <= '0;
        dec_rs2 <= '0;
        clear_inputs();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        run_phase(rooth_pkg::BRANCH_NONE, rooth_pkg::JUMP_NONE, 32'h0, 32'h0, 32'h0, 1'b0, 3'b100);
        run_phase(rooth_pkg::BRANCH_NONE, rooth_pkg::JUMP_NONE, 32'h0, 32'h0, 32'h0, 1'b1, 3'b000);
        run_phase(rooth_pkg::BRANCH_BEQ, rooth_pkg::JUMP_NONE, 32'h0000_0010,
                  32'h0000_0abc, 32'h0000_0abc, 1'b0, 3'b010);
        // signed compare would not take this one
        run_phase(rooth_pkg::BRANCH_BLTU, rooth_pkg::JUMP_NONE, 32'h0000_0100,
                  32'h0000_0005, 32'h8000_0000, 1'b0, 3'b010);
        run_phase(rooth_pkg::BRANCH_BNE, rooth_pkg::JUMP_NONE, 32'h0000_0020,
                  32'h1234_5678, 32'h1234_5678, 1'b0, 3'b100);
        run_phase(rooth_pkg::BRANCH_NONE, rooth_pkg::JUMP_JALR, 32'h0000_0040,
                  32'h0000_2000, 32'h0, 1'b0, 3'b001);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== rooth_flow_core.f ====
logic/rooth_pkg.sv
logic/branch_compare.sv
logic/pipeline_ctrl.sv
logic/pc_reg.sv
logic/flow_stage_reg.sv
logic/rooth_flow_core.sv
verification/rooth_flow_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module rooth_flow_core_tb \
    -f rooth_flow_core.f \
    -o rooth_flow_core_sim \
&& ./obj_dir/rooth_flow_core_sim | tee /dev/stderr | grep -qx "Result: PASSED" \
&& echo "simulation ok" \
|| { echo "simulation failed"; exit 1; }
